// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= controlUnitTb
FILELIST  ?= files.f
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: files.f
+incdir+sim
logic/cuPkg.sv
logic/opcodeDecoder.sv
logic/stepSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
sim/controlUnitTb.sv

// File: logic/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  logic             clk,
    input  logic             rst,
    input  cuPkg::opcode_t   opcode,
    input  logic             irq,
    output cuPkg::ctrlWord_t ctrl
);
    import cuPkg::*;

    logic        fetch;
    opcode_t     instrOp;
    instrClass_t instrCls;
    step_t       step;

    stepSequencer sequencer_i (
        .clk      (clk),
        .rst      (rst),
        .opcode   (opcode),
        .irq      (irq),
        .fetch    (fetch),
        .instrOp  (instrOp),
        .instrCls (instrCls),
        .step     (step)
    );

    // One register stage behind the sequencer
    controlWordGen generator_i (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .instrCls (instrCls),
        .instrOp  (instrOp),
        .step     (step),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// File: logic/controlWordGen.sv
`timescale 1ns/100ps
`default_nettype none

module controlWordGen (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch,
    input  cuPkg::instrClass_t instrCls,
    input  cuPkg::opcode_t     instrOp,
    input  cuPkg::step_t       step,
    output cuPkg::ctrlWord_t   ctrl
);
    import cuPkg::*;

    ctrlWord_t nxt;
    step_t     finalStep;
    logic      isLast;
    logic      haltPcDone;

    assign finalStep = CLASS_LEN(instrCls) - 1'b1;
    assign isLast = (step == finalStep);

    always_comb begin
        nxt = CTRL_IDLE;
        if (fetch) begin
            nxt.pcOut = 1'b1;
        end else begin
            if (instrCls != nop && instrCls != illegal) begin
                nxt.aluOp = instrOp;
            end
            case (instrCls)
                aluReg: nxt.regDst = selRd;
                load, pop, move: nxt.regDst = selRt;
                default: nxt.regDst = selRs;
            endcase
            nxt.aluSrc2 = (instrCls == aluImm) || (instrCls == load) ||
                          (instrCls == store);

            case (instrCls)
                aluReg, aluImm, load, move, store: begin
                    case (step)
                        3'd0: begin
                            nxt.zIn = 1'b1;
                        end
                        3'd1: begin
                            nxt.zOut = 1'b1;
                            if (instrCls == store) begin
                                nxt.memWrite = 1'b1;
                            end else begin
                                nxt.regWrite = 1'b1;
                                nxt.memToOut = (instrCls != load);  // Load takes memory data
                            end
                        end
                        default: ;
                    endcase
                    nxt.pcIn = isLast;
                end
                branch, nop: begin
                    nxt.pcIn = isLast;
                end
                push, call: begin
                    case (step)
                        3'd0: begin
                            nxt.zInSp = 1'b1;  // SP - 4
                        end
                        3'd1: begin
                            nxt.zOutSp = 1'b1;
                            nxt.spWrite = 1'b1;
                        end
                        3'd2: begin
                            nxt.zIn = 1'b1;
                            nxt.aluSrc1 = 1'b1;
                            nxt.writeDataSrc = (instrCls == call);
                        end
                        3'd3: begin
                            nxt.zOut = 1'b1;
                            nxt.memWrite = 1'b1;
                            nxt.writeDataSrc = (instrCls == call);
                        end
                        3'd4: begin
                            nxt.call = (instrCls == call);
                        end
                        3'd5: begin
                            nxt.call = (instrCls == call);  // Held while the target loads
                            nxt.pcIn = 1'b1;
                        end
                        default: ;
                    endcase
                end
                pop, ret: begin
                    case (step)
                        3'd0: begin
                            nxt.zIn = 1'b1;
                            nxt.aluSrc1 = 1'b1;
                            nxt.pcUpdate = (instrCls == ret);
                        end
                        3'd1: begin
                            nxt.zOut = 1'b1;
                            if (instrCls == ret) begin
                                nxt.pcUpdate = 1'b1;
                                nxt.pcIn = 1'b1;  // Return address from the stack
                            end else begin
                                nxt.regWrite = 1'b1;
                            end
                        end
                        3'd2: begin
                            nxt.zInSp = 1'b1;
                            nxt.spUpdate = 1'b1;
                        end
                        3'd3: begin
                            nxt.zOutSp = 1'b1;
                            nxt.spWrite = 1'b1;
                        end
                        default: ;
                    endcase
                    if (instrCls == pop) begin
                        nxt.pcIn = nxt.pcIn | isLast;
                    end
                end
                halt: begin
                    // PC advances once on entry to the wait
                    nxt.pcIn = isLast && !haltPcDone;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fetch) begin
            haltPcDone <= 1'b0;
        end else if (instrCls == halt && isLast) begin
            haltPcDone <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= CTRL_IDLE;
        end else begin
            ctrl <= nxt;
        end
    end

    noWriteClash: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.memWrite && ctrl.regWrite)
    ) else $error("memWrite and regWrite together");

    noPcClash: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.pcIn && ctrl.pcOut)
    ) else $error("pcIn and pcOut together");

endmodule

`default_nettype wire

// File: logic/cuPkg.sv
`default_nettype none

package cuPkg;

    localparam int OPCODE_W = 6;
    localparam int STEP_W = 3;  // Longest sequence is CALL with 7 steps

    typedef enum logic [OPCODE_W-1:0] {
        opRType = 6'd0,
        opAddi  = 6'd1,
        opSubi  = 6'd2,
        opAndi  = 6'd3,
        opOri   = 6'd4,
        opXori  = 6'd5,
        opNoti  = 6'd6,
        opSlli  = 6'd7,
        opSrli  = 6'd8,
        opSrai  = 6'd9,
        opLd    = 6'd10,
        opSt    = 6'd11,
        opLdsp  = 6'd12,
        opStsp  = 6'd13,
        opBr    = 6'd14,
        opBmi   = 6'd15,
        opBpl   = 6'd16,
        opBz    = 6'd17,
        opPush  = 6'd18,
        opPop   = 6'd19,
        opCall  = 6'd20,
        opRet   = 6'd21,
        opMove  = 6'd22,
        opHalt  = 6'd32,  // Waits for irq
        opNop   = 6'd33
    } opcode_t;

    typedef enum logic [3:0] {
        aluReg, aluImm, load, store, branch,
        push, pop, call, ret, move,
        halt, nop, illegal
    } instrClass_t;

    typedef logic [STEP_W-1:0] step_t;

    typedef enum logic [1:0] {
        selRs = 2'd0,
        selRt = 2'd1,
        selRd = 2'd2
    } regDst_t;

    typedef struct packed {
        logic                pcIn;
        logic                pcOut;
        logic                call;
        logic [OPCODE_W-1:0] aluOp;
        regDst_t             regDst;
        logic                regWrite;
        logic                aluSrc1;       // 1 selects SP
        logic                aluSrc2;       // 1 selects immediate
        logic                spWrite;
        logic                zIn;
        logic                zOut;
        logic                memToOut;      // 1 selects ALU result
        logic                pcUpdate;      // 1 takes PC from memory
        logic                memWrite;
        logic                writeDataSrc;  // 1 selects return PC
        logic                spUpdate;      // 1 increments SP
        logic                zInSp;
        logic                zOutSp;
    } ctrlWord_t;

    localparam ctrlWord_t CTRL_IDLE = '0;

    // Execute steps per class, fetch cycle not included
    function automatic step_t CLASS_LEN(instrClass_t cls);
        case (cls)
            aluReg, aluImm, load, store: return 3'd4;
            branch:                      return 3'd2;
            push, pop:                   return 3'd6;
            call:                        return 3'd7;
            ret:                         return 3'd5;
            move:                        return 3'd3;
            halt:                        return 3'd2;
            default:                     return 3'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/opcodeDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module opcodeDecoder (
    input  cuPkg::opcode_t     instrOp,
    output cuPkg::instrClass_t instrCls,
    output cuPkg::step_t       lastStep
);
    import cuPkg::*;

    always_comb begin
        case (instrOp)
            opRType: begin
                instrCls = aluReg;
            end
            opAddi, opSubi, opAndi, opOri, opXori,
            opNoti, opSlli, opSrli, opSrai: begin
                instrCls = aluImm;
            end
            opLd, opLdsp: begin
                instrCls = load;
            end
            opSt, opStsp: begin
                instrCls = store;
            end
            opBr, opBmi, opBpl, opBz: begin
                instrCls = branch;  // Condition is resolved in the datapath
            end
            opPush: begin
                instrCls = push;
            end
            opPop: begin
                instrCls = pop;
            end
            opCall: begin
                instrCls = call;
            end
            opRet: begin
                instrCls = ret;
            end
            opMove: begin
                instrCls = move;
            end
            opHalt: begin
                instrCls = halt;
            end
            opNop: begin
                instrCls = nop;
            end
            default: begin
                instrCls = illegal;
            end
        endcase
    end

    // Every class has at least one step
    assign lastStep = CLASS_LEN(instrCls) - 1'b1;

endmodule

`default_nettype wire

// File: logic/stepSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module stepSequencer (
    input  logic               clk,
    input  logic               rst,
    input  cuPkg::opcode_t     opcode,
    input  logic               irq,
    output logic               fetch,
    output cuPkg::opcode_t     instrOp,
    output cuPkg::instrClass_t instrCls,
    output cuPkg::step_t       step
);
    import cuPkg::*;

    step_t lastStep;
    logic  haltWait;
    logic  instrDone;

    opcodeDecoder decoder_i (
        .instrOp  (instrOp),
        .instrCls (instrCls),
        .lastStep (lastStep)
    );

    // HALT parks on its final step until irq is seen
    assign haltWait = (instrCls == halt) && !irq;
    assign instrDone = (step == lastStep) && !haltWait;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch <= 1'b1;
            instrOp <= opNop;
            step <= '0;
        end else if (fetch) begin
            fetch <= 1'b0;
            instrOp <= opcode;  // Sampled once per instruction
            step <= '0;
        end else if (instrDone) begin
            fetch <= 1'b1;
            step <= '0;
        end else if (step != lastStep) begin
            step <= step + 1'b1;
        end
    end

    stepInRange: assert property (
        @(posedge clk) disable iff (rst)
        !fetch |-> (step <= lastStep)
    ) else $error("step %0d passed last step %0d", step, lastStep);

endmodule

`default_nettype wire

// File: sim/cuTestTable.svh
`ifndef CU_TEST_TABLE_SVH
`define CU_TEST_TABLE_SVH

// Each row holds opcode, cycles from pcOut to pcOut, regWrite / memWrite / spWrite pulses,
// call seen, pcUpdate seen, regDst during regWrite, pcIn pulses and base irq delay
typedef struct packed {
    logic [5:0] op;
    int         len;
    int         regWr;
    int         memWr;
    int         spWr;
    int         callSeen;
    int         pcUpd;
    int         regDst;    // 0 rs, 1 rt, 2 rd
    int         pcIns;
    int         irqDelay;  // HALT rows only
} testRow_t;

localparam int NUM_ROWS = 31;

localparam testRow_t TEST_ROWS [NUM_ROWS] = '{
    '{6'd0,  5, 1, 0, 0, 0, 0, 2, 1, 0},  // R-type
    '{6'd1,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd2,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd3,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd4,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd5,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd6,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd7,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd8,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd9,  5, 1, 0, 0, 0, 0, 0, 1, 0},
    '{6'd10, 5, 1, 0, 0, 0, 0, 1, 1, 0},  // LD
    '{6'd11, 5, 0, 1, 0, 0, 0, 0, 1, 0},  // ST
    '{6'd12, 5, 1, 0, 0, 0, 0, 1, 1, 0},
    '{6'd13, 5, 0, 1, 0, 0, 0, 0, 1, 0},
    '{6'd14, 3, 0, 0, 0, 0, 0, 0, 1, 0},  // Branches
    '{6'd15, 3, 0, 0, 0, 0, 0, 0, 1, 0},
    '{6'd16, 3, 0, 0, 0, 0, 0, 0, 1, 0},
    '{6'd17, 3, 0, 0, 0, 0, 0, 0, 1, 0},
    '{6'd18, 7, 0, 1, 1, 0, 0, 0, 1, 0},  // PUSH
    '{6'd19, 7, 1, 0, 1, 0, 0, 1, 1, 0},  // POP
    '{6'd20, 8, 0, 1, 1, 1, 0, 0, 1, 0},  // CALL
    '{6'd21, 6, 0, 0, 1, 0, 1, 0, 1, 0},  // RET
    '{6'd22, 4, 1, 0, 0, 0, 0, 1, 1, 0},  // MOVE
    '{6'd32, 3, 0, 0, 0, 0, 0, 0, 1, 0},  // HALT
    '{6'd33, 2, 0, 0, 0, 0, 0, 0, 1, 0},  // NOP
    '{6'd23, 2, 0, 0, 0, 0, 0, 0, 0, 0},  // Illegal
    '{6'd32, 3, 0, 0, 0, 0, 0, 0, 1, 3},
    '{6'd32, 3, 0, 0, 0, 0, 0, 0, 1, 1},  // Back to back HALT
    '{6'd63, 2, 0, 0, 0, 0, 0, 0, 0, 0},
    '{6'd40, 2, 0, 0, 0, 0, 0, 0, 0, 0},
    '{6'd0,  5, 1, 0, 0, 0, 0, 2, 1, 0}
};

`endif

// File: sim/controlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;
    import cuPkg::*;

    `include "cuTestTable.svh"

    logic      clk;
    logic      rst;
    opcode_t   opcode;
    logic      irq;
    ctrlWord_t ctrl;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int irqWait [NUM_ROWS];

    controlUnit dut_i (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .irq    (irq),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input int actual, input int expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        testRow_t    row;
        ctrlWord_t   w;
        ctrlWord_t   fetchWord;
        int          cycles;
        int          regWr;
        int          memWr;
        int          spWr;
        int          pcIns;
        int          errorsBefore;
        int          total;
        logic        callSeen;
        logic        pcUpdSeen;
        logic        isHalt;

        rst = 1'b1;
        irq = 1'b0;
        opcode = opcode_t'(TEST_ROWS[0].op);
        void'($urandom(32'h8ebc4167));

        total = 6;  // Reset plus the first fetch
        for (int k = 0; k < NUM_ROWS; k++) begin
            irqWait[k] = 0;
            if (TEST_ROWS[k].op == opHalt) begin
                irqWait[k] = TEST_ROWS[k].irqDelay + int'($urandom % 4);  // Random extra wait
            end
            total += TEST_ROWS[k].len + irqWait[k];
        end
        cycleLimit = total + 50;

        fetchWord = CTRL_IDLE;
        fetchWord.pcOut = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkValue(int'(ctrl), int'(CTRL_IDLE), "control word after reset");
        @(posedge clk);
        checkValue(int'(ctrl), int'(fetchWord), "first control word");

        for (int k = 0; k < NUM_ROWS; k++) begin
            row = TEST_ROWS[k];
            isHalt = (row.op == opHalt);
            errorsBefore = errorCount;
            if (k + 1 < NUM_ROWS) begin
                opcode <= opcode_t'(TEST_ROWS[k + 1].op);  // Latched at the next fetch
            end else begin
                opcode <= opNop;
            end
            irq <= isHalt && (irqWait[k] == 0);
            cycles = 0;
            regWr = 0;
            memWr = 0;
            spWr = 0;
            pcIns = 0;
            callSeen = 1'b0;
            pcUpdSeen = 1'b0;

            do begin
                @(posedge clk);
                cycles++;
                w = ctrl;
                if (!w.pcOut) begin
                    if (isHalt && cycles == irqWait[k]) begin
                        irq <= 1'b1;
                    end
                    regWr += int'(w.regWrite);
                    memWr += int'(w.memWrite);
                    spWr += int'(w.spWrite);
                    pcIns += int'(w.pcIn);
                    callSeen = callSeen | w.call;
                    pcUpdSeen = pcUpdSeen | w.pcUpdate;
                    if (w.regWrite) begin
                        checkValue(int'(w.regDst), row.regDst, "regDst during regWrite");
                    end
                    if (w.memWrite) begin
                        checkValue(int'(w.writeDataSrc), row.callSeen, "writeDataSrc on memWrite");
                    end
                    if (w.zIn || w.regWrite || w.memWrite) begin
                        checkValue(int'(w.aluOp), int'(row.op), "aluOp");
                    end
                end
            end while (!w.pcOut);

            checkValue(int'(w), int'(fetchWord), "control word at fetch");
            checkValue(cycles, row.len + irqWait[k], "cycles between pcOut pulses");
            checkValue(regWr, row.regWr, "regWrite pulses");
            checkValue(memWr, row.memWr, "memWrite pulses");
            checkValue(spWr, row.spWr, "spWrite pulses");
            checkValue(pcIns, row.pcIns, "pcIn pulses");
            checkValue(int'(callSeen), row.callSeen, "call seen");
            checkValue(int'(pcUpdSeen), row.pcUpd, "pcUpdate seen");
            $display("Row %0d opcode %0d: %0d cycles, irq wait %0d, %s", k, row.op, cycles,
                     irqWait[k], (errorCount == errorsBefore) ? "ok" : "MISMATCH");
        end

        $display("Rows: %0d, checks: %0d, errors: %0d", NUM_ROWS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
